// ==== src/datapath_cfg.svh ====
`ifndef DATAPATH_CFG_SVH
`define DATAPATH_CFG_SVH

// width of the shared bus and of every register except Z
`define WORD_WIDTH 32

// number of general registers, one strobe bit each for load and to-bus
`define REG_COUNT 16

// width of the ALU operation code
`define OPCODE_WIDTH 5

`endif

// ==== src/aluPkg.sv ====
`default_nettype none

`include "datapath_cfg.svh"

package aluPkg;

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opShr  = 5'b00111,
        opShra = 5'b01000,
        opShl  = 5'b01001,
        opRol  = 5'b01010,
        opRor  = 5'b01011,
        opMul  = 5'b01100, // signed
        opDiv  = 5'b01101, // signed
        opNeg  = 5'b01110,
        opNot  = 5'b01111
    } aluOp;

    typedef struct packed {
        logic [`WORD_WIDTH-1:0] remainder; // lands in HI
        logic [`WORD_WIDTH-1:0] quotient;  // lands in LO
    } divPair;

    // Z holds either a full product or a remainder/quotient pair
    typedef union packed {
        logic signed [2*`WORD_WIDTH-1:0] product;
        divPair                          divResult;
    } zResult;

endpackage

`default_nettype wire

// ==== src/busPkg.sv ====
`default_nettype none

`include "datapath_cfg.svh"

package busPkg;

    // who is driving the shared bus this cycle
    typedef enum logic [3:0] {
        srcNone,
        srcReg,
        srcPc,
        srcZHigh,
        srcZLow,
        srcHi,
        srcLo,
        srcMdr,
        srcInPort,
        srcC
    } busSource;

    typedef logic [$clog2(`REG_COUNT)-1:0] regIndex;

endpackage

`default_nettype wire

// ==== src/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "datapath_cfg.svh"

module registerFile (
    input  logic                   Clock,
    input  logic                   reset,
    input  logic [`REG_COUNT-1:0]  regLoad,   // one bit per register
    input  logic [`WORD_WIDTH-1:0] writeData,
    input  busPkg::regIndex        readIndex,
    output logic [`WORD_WIDTH-1:0] readData
);

    logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (regLoad[i]) begin
                    regs[i] <= writeData; // several may load the same bus word
                end
            end
        end
    end

    assign readData = regs[readIndex]; // combinational read

endmodule

`default_nettype wire

// ==== src/busEncoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "datapath_cfg.svh"

module busEncoder (
    input  logic [`REG_COUNT-1:0] regToBus,
    input  logic                  pcToBus,
    input  logic                  zHighToBus,
    input  logic                  zLowToBus,
    input  logic                  hiToBus,
    input  logic                  loToBus,
    input  logic                  mdrToBus,
    input  logic                  inPortToBus,
    input  logic                  cToBus,
    output busPkg::busSource      source,
    output busPkg::regIndex       regSelect
);

    import busPkg::*;

    logic regHit;

    // scan downward so the lowest set index wins
    always_comb begin
        regHit    = 1'b0;
        regSelect = '0;
        for (int i = `REG_COUNT - 1; i >= 0; i--) begin
            if (regToBus[i]) begin
                regHit    = 1'b1;
                regSelect = regIndex'(i);
            end
        end
    end

    always_comb begin
        if (regHit)           source = srcReg;
        else if (pcToBus)     source = srcPc;
        else if (zHighToBus)  source = srcZHigh;
        else if (zLowToBus)   source = srcZLow;
        else if (hiToBus)     source = srcHi;
        else if (loToBus)     source = srcLo;
        else if (mdrToBus)    source = srcMdr;
        else if (inPortToBus) source = srcInPort;
        else if (cToBus)      source = srcC;
        else                  source = srcNone; // bus floats to zero
    end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "datapath_cfg.svh"

module alu (
    input  logic [`WORD_WIDTH-1:0] a,      // from Y
    input  logic [`WORD_WIDTH-1:0] b,      // from the bus
    input  aluPkg::aluOp           opcode,
    output aluPkg::zResult         result
);

    import aluPkg::*;

    localparam int W = `WORD_WIDTH;
    localparam int SHIFT_BITS = $clog2(W);

    logic [SHIFT_BITS-1:0] amount;
    logic [2*W-1:0]        rolWide;
    logic [2*W-1:0]        rorWide;
    logic signed [2*W-1:0] product;
    logic signed [W-1:0]   quotient;
    logic signed [W-1:0]   remainder;
    logic [W-1:0]          lowWord;

    assign amount = b[SHIFT_BITS-1:0];

    // rotate by shifting a doubled copy of the word
    assign rolWide = {a, a} << amount;
    assign rorWide = {a, a} >> amount;

    assign product = $signed(a) * $signed(b);

    always_comb begin
        if (b == '0) begin
            quotient  = '1; // divide by zero
            remainder = $signed(a);
        end else begin
            quotient  = $signed(a) / $signed(b);
            remainder = $signed(a) % $signed(b);
        end
    end

    always_comb begin
        case (opcode)
            opAdd:   lowWord = a + b;
            opSub:   lowWord = a - b;
            opAnd:   lowWord = a & b;
            opOr:    lowWord = a | b;
            opShr:   lowWord = a >> amount;
            opShra:  lowWord = $signed(a) >>> amount;
            opShl:   lowWord = a << amount;
            opRol:   lowWord = rolWide[2*W-1:W];
            opRor:   lowWord = rorWide[W-1:0];
            opNeg:   lowWord = -b;
            opNot:   lowWord = ~b;
            default: lowWord = '0; // mul and div use the wide views
        endcase
    end

    always_comb begin
        result = '0;
        case (opcode)
            opMul: begin
                result.product = product;
            end
            opDiv: begin
                result.divResult.remainder = remainder;
                result.divResult.quotient  = quotient;
            end
            default: begin
                result.product = {{W{1'b0}}, lowWord}; // high word zero
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "datapath_cfg.svh"

module datapath (
    input  logic                    Clock,
    input  logic                    reset,
    input  logic [`REG_COUNT-1:0]   regToBus,
    input  logic                    pcToBus,
    input  logic                    zHighToBus,
    input  logic                    zLowToBus,
    input  logic                    hiToBus,
    input  logic                    loToBus,
    input  logic                    mdrToBus,
    input  logic                    inPortToBus,
    input  logic                    cToBus,
    input  logic                    pcLoad,
    input  logic                    irLoad,
    input  logic                    marLoad,
    input  logic                    mdrLoad,
    input  logic                    yLoad,
    input  logic                    zLoad,
    input  logic                    hiLoad,
    input  logic                    loLoad,
    input  logic [`REG_COUNT-1:0]   regLoad,
    input  logic                    incPc,
    input  logic                    read,
    input  logic [`OPCODE_WIDTH-1:0] opcode,
    input  logic [`WORD_WIDTH-1:0]  mDataIn,
    input  logic [`WORD_WIDTH-1:0]  inPort,
    output logic [`WORD_WIDTH-1:0]  busValue,
    output logic [`WORD_WIDTH-1:0]  marValue,
    output logic [`WORD_WIDTH-1:0]  pcValue,
    output logic [`WORD_WIDTH-1:0]  irValue
);

    import aluPkg::*;
    import busPkg::*;

    localparam int W = `WORD_WIDTH;
    localparam int C_BITS = 19; // constant field of the IR

    logic [W-1:0] pcReg, irReg, marReg, mdrReg, yReg, hiReg, loReg;
    logic [W-1:0] regData;
    logic [W-1:0] cValue;
    zResult       zReg;
    zResult       aluResult;
    busSource     source;
    regIndex      regSelect;

    registerFile i_registerFile (
        .Clock     (Clock),
        .reset     (reset),
        .regLoad   (regLoad),
        .writeData (busValue),
        .readIndex (regSelect),
        .readData  (regData)
    );

    busEncoder i_busEncoder (
        .regToBus    (regToBus),
        .pcToBus     (pcToBus),
        .zHighToBus  (zHighToBus),
        .zLowToBus   (zLowToBus),
        .hiToBus     (hiToBus),
        .loToBus     (loToBus),
        .mdrToBus    (mdrToBus),
        .inPortToBus (inPortToBus),
        .cToBus      (cToBus),
        .source      (source),
        .regSelect   (regSelect)
    );

    alu i_alu (
        .a      (yReg),
        .b      (busValue),
        .opcode (aluOp'(opcode)),
        .result (aluResult)
    );

    assign cValue = {{(W - C_BITS){irReg[C_BITS-1]}}, irReg[C_BITS-1:0]};

    always_comb begin
        case (source)
            srcReg:    busValue = regData;
            srcPc:     busValue = pcReg;
            srcZHigh:  busValue = zReg.product[2*W-1:W];
            srcZLow:   busValue = zReg.product[W-1:0];
            srcHi:     busValue = hiReg;
            srcLo:     busValue = loReg;
            srcMdr:    busValue = mdrReg;
            srcInPort: busValue = inPort;
            srcC:      busValue = cValue;
            default:   busValue = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            pcReg  <= '0;
            irReg  <= '0;
            marReg <= '0;
            mdrReg <= '0;
            yReg   <= '0;
            zReg   <= '0;
            hiReg  <= '0;
            loReg  <= '0;
        end else begin
            if (pcLoad)  pcReg  <= incPc ? pcReg + 1'b1 : busValue;
            if (irLoad)  irReg  <= busValue;
            if (marLoad) marReg <= busValue;
            if (mdrLoad) mdrReg <= read ? mDataIn : busValue; // memory or bus
            if (yLoad)   yReg   <= busValue;
            if (zLoad)   zReg   <= aluResult;
            if (hiLoad)  hiReg  <= busValue;
            if (loLoad)  loReg  <= busValue;
        end
    end

    assign marValue = marReg;
    assign pcValue  = pcReg;
    assign irValue  = irReg;

endmodule

`default_nettype wire

// ==== testbench/datapath_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "datapath_cfg.svh"

module datapath_assertions (
    input logic                   Clock,
    input logic                   reset,
    input logic [`REG_COUNT-1:0]  regToBus,
    input logic                   pcToBus,
    input logic                   zHighToBus,
    input logic                   zLowToBus,
    input logic                   hiToBus,
    input logic                   loToBus,
    input logic                   mdrToBus,
    input logic                   inPortToBus,
    input logic                   cToBus,
    input logic                   marLoad,
    input logic [`WORD_WIDTH-1:0] marValue,
    input logic [`WORD_WIDTH-1:0] busValue,
    input logic [`WORD_WIDTH-1:0] pcValue,
    input busPkg::busSource       source
);

    import busPkg::*;

    // MAR may only move on the edge that follows a marLoad cycle
    marOnlyOnLoad: assert property (@(posedge Clock) disable iff (reset)
        !$stable(marValue) |-> $past(marLoad))
        else $error("marValue changed without marLoad");

    // no strobe high means no source and a quiet bus
    idleBusIsZero: assert property (@(posedge Clock) disable iff (reset)
        (regToBus == '0 && !pcToBus && !zHighToBus && !zLowToBus && !hiToBus
         && !loToBus && !mdrToBus && !inPortToBus && !cToBus)
        |-> (source == srcNone && busValue == '0))
        else $error("bus not zero with no source selected");

    pcClearedByReset: assert property (@(posedge Clock)
        $past(reset) |-> (pcValue == '0))
        else $error("pcValue not zero after reset");

endmodule

bind datapath datapath_assertions i_assertions (
    .Clock       (Clock),
    .reset       (reset),
    .regToBus    (regToBus),
    .pcToBus     (pcToBus),
    .zHighToBus  (zHighToBus),
    .zLowToBus   (zLowToBus),
    .hiToBus     (hiToBus),
    .loToBus     (loToBus),
    .mdrToBus    (mdrToBus),
    .inPortToBus (inPortToBus),
    .cToBus      (cToBus),
    .marLoad     (marLoad),
    .marValue    (marValue),
    .busValue    (busValue),
    .pcValue     (pcValue),
    .source      (source)
);

`default_nettype wire

// ==== testbench/datapathTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "datapath_cfg.svh"

module datapathTb;

    import aluPkg::*;

    localparam int PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int FIXED_ROWS = 15;
    localparam int RANDOM_ROWS = 13;
    localparam int CYCLES_PER_ROW = 12;
    localparam int OTHER_CYCLES = 60; // reset checks, priority, PC and IR tests
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + OTHER_CYCLES
                                  + (FIXED_ROWS + RANDOM_ROWS) * CYCLES_PER_ROW + 100;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  op;
        logic [3:0]  dest;
        logic [31:0] expLo;
        logic [31:0] expHi;
    } opRow;

    // operands, opcode, destination, expected low and high words
    opRow opTable [FIXED_ROWS] = '{
        '{32'h0000_0005, 32'h0000_0003, opAdd,  4'd1,  32'h0000_0008, 32'h0},
        '{32'h0000_0003, 32'h0000_0005, opSub,  4'd2,  32'hFFFF_FFFE, 32'h0},
        '{32'hF0F0_1234, 32'h0FF0_FF00, opAnd,  4'd3,  32'h00F0_1200, 32'h0},
        '{32'hF000_000F, 32'h0000_F0F0, opOr,   4'd5,  32'hF000_F0FF, 32'h0},
        '{32'h8000_0010, 32'h0000_0004, opShr,  4'd7,  32'h0800_0001, 32'h0},
        '{32'h8000_0010, 32'h0000_0004, opShra, 4'd8,  32'hF800_0001, 32'h0},
        '{32'h0000_00FF, 32'h0000_0008, opShl,  4'd9,  32'h0000_FF00, 32'h0},
        '{32'h8000_0001, 32'h0000_0001, opRol,  4'd10, 32'h0000_0003, 32'h0},
        '{32'h8000_0001, 32'h0000_0001, opRor,  4'd11, 32'hC000_0000, 32'h0},
        '{32'hFFFF_FFFE, 32'h0000_0003, opMul,  4'd12, 32'hFFFF_FFFA, 32'hFFFF_FFFF},
        '{32'h0001_0000, 32'h0001_0000, opMul,  4'd13, 32'h0000_0000, 32'h0000_0001},
        '{32'hFFFF_FFF9, 32'h0000_0002, opDiv,  4'd14, 32'hFFFF_FFFD, 32'hFFFF_FFFF},
        '{32'h0000_0064, 32'h0000_0000, opDiv,  4'd15, 32'hFFFF_FFFF, 32'h0000_0064},
        '{32'h1111_1111, 32'h0000_0005, opNeg,  4'd0,  32'hFFFF_FFFB, 32'h0},
        '{32'h2222_2222, 32'h0F0F_0000, opNot,  4'd1,  32'hF0F0_FFFF, 32'h0}
    };

    logic [4:0] opList [13] = '{opAdd, opSub, opAnd, opOr, opShr, opShra, opShl,
                                opRol, opRor, opMul, opDiv, opNeg, opNot};

    logic                     Clock, reset;
    logic [`REG_COUNT-1:0]    regToBus, regLoad;
    logic                     pcToBus, zHighToBus, zLowToBus, hiToBus, loToBus;
    logic                     mdrToBus, inPortToBus, cToBus;
    logic                     pcLoad, irLoad, marLoad, mdrLoad, yLoad, zLoad, hiLoad, loLoad;
    logic                     incPc, read;
    logic [`OPCODE_WIDTH-1:0] opcode;
    logic [`WORD_WIDTH-1:0]   mDataIn, inPort, busValue, marValue, pcValue, irValue;
    logic [31:0]              lfsrState;
    int                       errorCount;

    datapath i_dut (.*);

    initial begin
        Clock = 1'b0;
        forever #(PERIOD / 2) Clock = ~Clock;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic drawWord(output logic [31:0] word);
        for (int i = 0; i < 32; i++) begin
            lfsrState = lfsrStep(lfsrState);
            word[i] = lfsrState[0];
        end
    endtask

    // expected {high, low} of Z from the ALU rules
    function automatic logic [63:0] modelResult(input logic [4:0] op,
                                                input logic [31:0] a, input logic [31:0] b);
        logic [4:0]         n;
        logic [31:0]        low;
        logic [31:0]        high;
        logic [63:0]        wide;
        logic signed [31:0] q;
        logic signed [31:0] r;
        n = b[4:0];
        low = '0;
        high = '0;
        case (op)
            opAdd:  low = a + b;
            opSub:  low = a - b;
            opAnd:  low = a & b;
            opOr:   low = a | b;
            opShr:  low = a >> n;
            opShra: low = $signed(a) >>> n;
            opShl:  low = a << n;
            opRol:  low = (n == 0) ? a : ((a << n) | (a >> (32 - n)));
            opRor:  low = (n == 0) ? a : ((a >> n) | (a << (32 - n)));
            opNeg:  low = 32'h0 - b;
            opNot:  low = ~b;
            opMul: begin
                wide = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                {high, low} = wide;
            end
            opDiv: begin
                if (b == 0) begin
                    low = 32'hFFFF_FFFF;
                    high = a; // dividend kept as remainder
                end else begin
                    q = $signed(a) / $signed(b);
                    r = $signed(a) - q * $signed(b);
                    low = q;
                    high = r;
                end
            end
            default: low = '0;
        endcase
        return {high, low};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic clearStrobes();
        regToBus = '0;
        regLoad = '0;
        opcode = '0;
        {pcToBus, zHighToBus, zLowToBus, hiToBus, loToBus, mdrToBus, inPortToBus, cToBus} = '0;
        {pcLoad, irLoad, marLoad, mdrLoad, yLoad, zLoad, hiLoad, loLoad, incPc, read} = '0;
    endtask

    task automatic nextCycle();
        @(negedge Clock);
        clearStrobes();
    endtask

    task automatic checkBus(input string name, input logic [31:0] expected);
        #1 checkValue(name, busValue, expected);
    endtask

    // memory word into MDR, then MDR over the bus into a register
    task automatic loadRegister(input int index, input logic [31:0] value);
        nextCycle();
        read = 1'b1;
        mdrLoad = 1'b1;
        mDataIn = value;
        nextCycle();
        mdrToBus = 1'b1;
        regLoad[index] = 1'b1;
        checkBus("busValue", value);
    endtask

    task automatic readRegister(input int index, input logic [31:0] expected);
        nextCycle();
        regToBus[index] = 1'b1;
        checkBus($sformatf("register %0d", index), expected);
    endtask

    task automatic loadIrAndCheck(input logic [31:0] word, input logic [31:0] expectedC);
        nextCycle();
        read = 1'b1;
        mdrLoad = 1'b1;
        mDataIn = word;
        nextCycle();
        mdrToBus = 1'b1;
        irLoad = 1'b1;
        nextCycle();
        cToBus = 1'b1;
        #1 checkValue("irValue", irValue, word);
        checkValue("busValue (C)", busValue, expectedC);
    endtask

    task automatic applyRow(input logic [31:0] a, input logic [31:0] b, input logic [4:0] op,
                            input int dest, input logic [31:0] expLo, input logic [31:0] expHi);
        logic wide;
        wide = (op == opMul) || (op == opDiv);
        loadRegister(4, a);
        loadRegister(6, b);
        nextCycle();
        regToBus[4] = 1'b1;
        yLoad = 1'b1;
        nextCycle();
        regToBus[6] = 1'b1;
        opcode = op;
        zLoad = 1'b1;
        nextCycle();
        zLowToBus = 1'b1;
        regLoad[dest] = 1'b1;
        loLoad = wide;
        checkBus("zLow", expLo);
        nextCycle();
        zHighToBus = 1'b1;
        hiLoad = wide;
        checkBus("zHigh", expHi);
        readRegister(dest, expLo);
        if (wide) begin
            nextCycle();
            hiToBus = 1'b1;
            checkBus("HI", expHi);
            nextCycle();
            loToBus = 1'b1;
            checkBus("LO", expLo);
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] expected;
        logic [4:0]  op;
        errorCount = 0;
        lfsrState = 32'd23;
        reset = 1'b1;
        clearStrobes();
        mDataIn = '0;
        inPort = '0;
        repeat (RESET_CYCLES) @(negedge Clock);
        reset = 1'b0;

        nextCycle();
        #1 checkValue("busValue", busValue, 32'h0);
        checkValue("pcValue", pcValue, 32'h0);
        checkValue("marValue", marValue, 32'h0);
        checkValue("irValue", irValue, 32'h0);
        for (int i = 0; i < `REG_COUNT; i++) begin
            readRegister(i, 32'h0);
        end

        loadRegister(4, 32'h1234_5678);
        loadRegister(6, 32'hCAFE_0042);
        readRegister(4, 32'h1234_5678);
        readRegister(6, 32'hCAFE_0042);
        nextCycle();
        regToBus[4] = 1'b1;
        regToBus[6] = 1'b1;
        mdrToBus = 1'b1;
        checkBus("busValue (priority)", 32'h1234_5678); // lowest index wins

        nextCycle();
        inPort = 32'h00C0_FFEE;
        inPortToBus = 1'b1;
        cToBus = 1'b1;
        checkBus("busValue (inPort)", 32'h00C0_FFEE); // input port ahead of C

        for (int k = 0; k < 2; k++) begin
            nextCycle();
            pcToBus = 1'b1;
            marLoad = 1'b1;
            pcLoad = 1'b1;
            incPc = 1'b1;
            nextCycle();
            #1 checkValue("marValue", marValue, k);
            checkValue("pcValue", pcValue, k + 1);
        end

        loadIrAndCheck(32'h1235_4321, 32'hFFFD_4321);
        loadIrAndCheck(32'hABC3_1234, 32'h0003_1234);

        for (int r = 0; r < FIXED_ROWS; r++) begin
            applyRow(opTable[r].a, opTable[r].b, opTable[r].op, opTable[r].dest,
                     opTable[r].expLo, opTable[r].expHi);
        end

        for (int k = 0; k < RANDOM_ROWS; k++) begin
            drawWord(a);
            drawWord(b);
            op = opList[k % 13];
            expected = modelResult(op, a, b);
            applyRow(a, b, op, 1 + (k % 15), expected[31:0], expected[63:32]);
        end

        nextCycle();
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * PERIOD);
        $display("watchdog expired before the tests completed");
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== datapath.f ====
+incdir+src
src/aluPkg.sv
src/busPkg.sv
src/registerFile.sv
src/busEncoder.sv
src/alu.sv
src/datapath.sv
testbench/datapath_assertions.sv
testbench/datapathTb.sv

// ==== Makefile ====
TOP = datapathTb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f datapath.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f datapath.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
